//--- pru_pkg.sv
`default_nettype none

package pru_pkg;

    typedef enum logic [1:0] {
        shape_rect   = 2'd0,
        shape_circle = 2'd1,
        shape_none   = 2'd2   // no pixels, done right away
    } pru_shape_e;

    typedef enum logic [1:0] {
        ld_idle   = 2'd0,
        ld_load_2 = 2'd1,     // word 0 taken, waiting for word 1
        ld_wait   = 2'd2      // draw pending in the engine
    } pru_load_e;

    localparam int pru_col_w   = 10;
    localparam int pru_row_w   = 9;
    localparam int pru_color_w = 2;
    localparam int pru_rgb_w   = 10;

    // command word 0 fields
    localparam int pru_w0_col_lsb   = 0;
    localparam int pru_w0_row_lsb   = 10;
    localparam int pru_w0_color_lsb = 19;
    localparam int pru_w0_shape_lsb = 21;
    localparam int pru_w0_sub_bit   = 23;

    // command word 1 fields
    localparam int pru_w1_width_lsb = 0;
    localparam int pru_w1_hr_lsb    = 10;

    // word addresses on the bus
    localparam logic [31:0] pru_addr_cmd0 = 32'h100;
    localparam logic [31:0] pru_addr_cmd1 = 32'h101;
    localparam logic [31:0] pru_addr_pal  = 32'h110;  // four entries

    localparam int pru_pal_red_lsb   = 20;
    localparam int pru_pal_green_lsb = 10;
    localparam int pru_pal_blue_lsb  = 0;

    // black, red, green, blue
    localparam logic [3*pru_rgb_w-1:0] pru_pal_reset [4] = '{
        {10'h000, 10'h000, 10'h000},
        {10'h3ff, 10'h000, 10'h000},
        {10'h000, 10'h3ff, 10'h000},
        {10'h000, 10'h000, 10'h3ff}
    };

endpackage

`default_nettype wire

//--- pru_cmd_regs.sv
`timescale 1ns/1ns
`default_nettype none

module pru_cmd_regs
    import pru_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [31:0]            bus_addr,
    input  wire logic [31:0]            bus_data,
    input  wire logic                   bus_write,
    input  wire logic                   busy,
    output logic                        bus_ack,
    output logic [pru_color_w-1:0]      color,
    output logic [pru_row_w-1:0]        row,
    output logic [pru_col_w-1:0]        col,
    output logic [pru_col_w-1:0]        width,
    output logic [pru_row_w-1:0]        height_radius,
    output pru_shape_e                  shape_select,
    output logic                        subtract,
    output logic                        start,
    output logic                        in_idle,
    output logic                        in_load_2,
    output logic [pru_rgb_w-1:0]        pal_red [4],
    output logic [pru_rgb_w-1:0]        pal_green [4],
    output logic [pru_rgb_w-1:0]        pal_blue [4]
);

    pru_load_e  ld_state;
    logic       busy_q;      // for the falling edge of busy
    logic       is_cmd0;
    logic       is_cmd1;
    logic       is_pal;
    logic       cmd_ok;
    logic       accept;
    logic [1:0] pal_idx;

    assign is_cmd0 = (bus_addr == pru_addr_cmd0);
    assign is_cmd1 = (bus_addr == pru_addr_cmd1);
    assign is_pal  = (bus_addr[31:2] == pru_addr_pal[31:2]);
    assign pal_idx = bus_addr[1:0];

    // back-pressure: command words wait while a draw is pending
    assign cmd_ok = !busy && (is_cmd0 ? (ld_state == ld_idle) : (ld_state != ld_wait));
    assign accept = bus_write && !bus_ack && (cmd_ok || !(is_cmd0 || is_cmd1));

    assign in_idle   = (ld_state == ld_idle);
    assign in_load_2 = (ld_state == ld_load_2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_state <= ld_idle;
            bus_ack  <= 1'b0;
            start    <= 1'b0;
            busy_q   <= 1'b0;
        end else begin
            bus_ack <= accept;   // one cycle, gated by !bus_ack above
            start   <= 1'b0;
            busy_q  <= busy;
            case (ld_state)
                ld_idle: begin
                    if (accept && is_cmd0)
                        ld_state <= ld_load_2;
                end
                ld_load_2: begin
                    if (accept && is_cmd1) begin
                        ld_state <= ld_wait;
                        start    <= 1'b1;
                    end
                end
                ld_wait: begin
                    if (busy_q && !busy)   // engine finished
                        ld_state <= ld_idle;
                end
                default: ld_state <= ld_idle;
            endcase
        end
    end

    // command fields, held until the next command
    always_ff @(posedge clk) begin
        if (accept && is_cmd0) begin
            col          <= bus_data[pru_w0_col_lsb +: pru_col_w];
            row          <= bus_data[pru_w0_row_lsb +: pru_row_w];
            color        <= bus_data[pru_w0_color_lsb +: pru_color_w];
            shape_select <= pru_shape_e'(bus_data[pru_w0_shape_lsb +: 2]);
            subtract     <= bus_data[pru_w0_sub_bit];
        end
        if (accept && is_cmd1 && ld_state == ld_load_2) begin
            width         <= bus_data[pru_w1_width_lsb +: pru_col_w];
            height_radius <= bus_data[pru_w1_hr_lsb +: pru_row_w];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                pal_red[i]   <= pru_pal_reset[i][pru_pal_red_lsb +: pru_rgb_w];
                pal_green[i] <= pru_pal_reset[i][pru_pal_green_lsb +: pru_rgb_w];
                pal_blue[i]  <= pru_pal_reset[i][pru_pal_blue_lsb +: pru_rgb_w];
            end
        end else if (accept && is_pal) begin
            pal_red[pal_idx]   <= bus_data[pru_pal_red_lsb +: pru_rgb_w];
            pal_green[pal_idx] <= bus_data[pru_pal_green_lsb +: pru_rgb_w];
            pal_blue[pal_idx]  <= bus_data[pru_pal_blue_lsb +: pru_rgb_w];
        end
    end

endmodule

`default_nettype wire

//--- pru_draw_engine.sv
`timescale 1ns/1ns
`default_nettype none

module pru_draw_engine
    import pru_pkg::*;
#(
    parameter int fb_width  = 64,
    parameter int fb_height = 48
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     start,
    input  wire logic [pru_color_w-1:0]   color,
    input  wire logic [pru_row_w-1:0]     row,
    input  wire logic [pru_col_w-1:0]     col,
    input  wire logic [pru_col_w-1:0]     width,
    input  wire logic [pru_row_w-1:0]     height_radius,
    input  wire pru_shape_e               shape_select,
    input  wire logic                     subtract,
    output logic                          busy,
    output logic                          done,
    output logic                          fb_we,
    output logic [$clog2(fb_width*fb_height)-1:0] fb_waddr,
    output logic [pru_color_w-1:0]        fb_wdata
);

    localparam int aw = $clog2(fb_width * fb_height);

    typedef enum logic {
        eng_idle,
        eng_scan
    } eng_state_e;

    eng_state_e         state;
    logic [10:0]        x_off;      // offset inside the bounding box
    logic [10:0]        y_off;
    logic [10:0]        x_last;
    logic [10:0]        y_last;
    logic               is_circle;
    logic signed [12:0] rel_x;      // offset from the circle centre
    logic signed [12:0] rel_y;
    logic signed [12:0] px;         // frame coordinates, may be negative
    logic signed [12:0] py;
    logic [25:0]        dist2;
    logic [25:0]        rad2;
    logic               in_shape;
    logic               in_frame;

    assign busy      = (state == eng_scan);
    assign is_circle = (shape_select == shape_circle);

    // pixel under test
    assign rel_x = $signed({2'b00, x_off}) - (is_circle ? $signed({4'b0, height_radius}) : 13'sd0);
    assign rel_y = $signed({2'b00, y_off}) - (is_circle ? $signed({4'b0, height_radius}) : 13'sd0);
    assign px    = $signed({3'b000, col}) + rel_x;
    assign py    = $signed({4'b0000, row}) + rel_y;
    assign dist2 = 26'(rel_x * rel_x) + 26'(rel_y * rel_y);
    assign rad2  = 26'(height_radius) * 26'(height_radius);

    always_comb begin
        case (shape_select)
            shape_rect:   in_shape = (x_off < 11'(width)) && (y_off < 11'(height_radius));
            shape_circle: in_shape = (dist2 <= rad2);
            default:      in_shape = 1'b0;
        endcase
    end

    // clip at all four frame edges
    assign in_frame = (px >= 0) && (px < fb_width) && (py >= 0) && (py < fb_height);

    assign fb_we    = busy && in_shape && in_frame;
    assign fb_waddr = aw'(int'(py) * fb_width + int'(px));
    assign fb_wdata = subtract ? '0 : color;   // erase draws background

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= eng_idle;
            done  <= 1'b0;
            x_off <= '0;
            y_off <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                eng_idle: begin
                    if (start) begin
                        state <= eng_scan;
                        x_off <= '0;
                        y_off <= '0;
                    end
                end
                eng_scan: begin
                    if (x_off == x_last) begin
                        x_off <= '0;
                        if (y_off == y_last) begin
                            state <= eng_idle;
                            done  <= 1'b1;   // same edge busy falls
                        end else begin
                            y_off <= y_off + 11'd1;
                        end
                    end else begin
                        x_off <= x_off + 11'd1;
                    end
                end
                default: state <= eng_idle;
            endcase
        end
    end

    // bounding box size, at least one cycle
    always_ff @(posedge clk) begin
        if (start && state == eng_idle) begin
            case (shape_select)
                shape_rect: begin
                    x_last <= (width == '0) ? '0 : 11'(width) - 11'd1;
                    y_last <= (height_radius == '0) ? '0 : 11'(height_radius) - 11'd1;
                end
                shape_circle: begin
                    x_last <= {1'b0, height_radius, 1'b0};   // 2r
                    y_last <= {1'b0, height_radius, 1'b0};
                end
                default: begin
                    x_last <= '0;
                    y_last <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- pru_frame_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module pru_frame_buffer
    import pru_pkg::*;
#(
    parameter int fb_width  = 64,
    parameter int fb_height = 48
) (
    input  wire logic                                 clk,
    input  wire logic                                 fb_we,
    input  wire logic [$clog2(fb_width*fb_height)-1:0] fb_waddr,
    input  wire logic [pru_color_w-1:0]               fb_wdata,
    input  wire logic                                 vga_ctrl_clk,
    input  wire logic [$clog2(fb_width*fb_height)-1:0] rd_addr,
    output logic [pru_color_w-1:0]                    rd_data
);

    localparam int depth = fb_width * fb_height;

    logic [pru_color_w-1:0] mem [depth];   // one colour index per pixel

    // drawing side
    always_ff @(posedge clk) begin
        if (fb_we)
            mem[fb_waddr] <= fb_wdata;
    end

    // display side, registered read
    always_ff @(posedge vga_ctrl_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- pru_vga_scan.sv
`timescale 1ns/1ns
`default_nettype none

module pru_vga_scan
    import pru_pkg::*;
#(
    parameter int fb_width  = 64,
    parameter int fb_height = 48
) (
    input  wire logic                        vga_ctrl_clk,
    input  wire logic                        rst_n,
    input  wire logic                        vga_read,
    input  wire logic [pru_color_w-1:0]      rd_data,
    input  wire logic [pru_rgb_w-1:0]        pal_red [4],
    input  wire logic [pru_rgb_w-1:0]        pal_green [4],
    input  wire logic [pru_rgb_w-1:0]        pal_blue [4],
    output logic [$clog2(fb_width*fb_height)-1:0] rd_addr,
    output logic [pru_rgb_w-1:0]             vga_red,
    output logic [pru_rgb_w-1:0]             vga_green,
    output logic [pru_rgb_w-1:0]             vga_blue
);

    localparam int depth = fb_width * fb_height;
    localparam int aw    = $clog2(depth);

    logic [aw-1:0] scan_addr;   // next pixel to fetch
    logic [1:0]    rd_valid;    // [0] address issued, [1] memory data ready

    always_ff @(posedge vga_ctrl_clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_addr <= '0;
            rd_addr   <= '0;
            rd_valid  <= '0;
        end else begin
            rd_valid <= {rd_valid[0], vga_read};
            if (vga_read) begin
                rd_addr   <= scan_addr;
                scan_addr <= (scan_addr == aw'(depth - 1)) ? '0 : scan_addr + 1'b1;
            end
        end
    end

    // palette lookup, outputs hold between reads
    always_ff @(posedge vga_ctrl_clk or negedge rst_n) begin
        if (!rst_n) begin
            vga_red   <= '0;
            vga_green <= '0;
            vga_blue  <= '0;
        end else if (rd_valid[1]) begin
            vga_red   <= pal_red[rd_data];
            vga_green <= pal_green[rd_data];
            vga_blue  <= pal_blue[rd_data];
        end
    end

endmodule

`default_nettype wire

//--- pru_top.sv
`timescale 1ns/1ns
`default_nettype none

module pru_top
    import pru_pkg::*;
#(
    parameter int fb_width  = 64,
    parameter int fb_height = 48
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  vga_ctrl_clk,
    input  wire logic                  vga_read,
    input  wire logic [31:0]           bus_addr,
    input  wire logic [31:0]           bus_data,
    input  wire logic                  bus_write,
    output wire logic                  bus_ack,
    output wire logic [pru_rgb_w-1:0]  vga_red,
    output wire logic [pru_rgb_w-1:0]  vga_green,
    output wire logic [pru_rgb_w-1:0]  vga_blue,
    output wire logic                  pru_start,
    output wire logic                  pru_done,
    output wire logic                  in_idle,
    output wire logic                  in_load_2
);

    localparam int aw = $clog2(fb_width * fb_height);

    // command path
    wire logic [pru_color_w-1:0] color;
    wire logic [pru_row_w-1:0]   row;
    wire logic [pru_col_w-1:0]   col;
    wire logic [pru_col_w-1:0]   width;
    wire logic [pru_row_w-1:0]   height_radius;
    wire pru_shape_e             shape_select;
    wire logic                   subtract;
    wire logic                   busy;

    // pixel write and scan-out
    wire logic                   fb_we;
    wire logic [aw-1:0]          fb_waddr;
    wire logic [pru_color_w-1:0] fb_wdata;
    wire logic [aw-1:0]          rd_addr;
    wire logic [pru_color_w-1:0] rd_data;
    wire logic [pru_rgb_w-1:0]   pal_red [4];
    wire logic [pru_rgb_w-1:0]   pal_green [4];
    wire logic [pru_rgb_w-1:0]   pal_blue [4];

    pru_cmd_regs cmd_regs0 (
        .clk(clk), .rst_n(rst_n),
        .bus_addr(bus_addr), .bus_data(bus_data), .bus_write(bus_write),
        .busy(busy), .bus_ack(bus_ack),
        .color(color), .row(row), .col(col), .width(width),
        .height_radius(height_radius), .shape_select(shape_select),
        .subtract(subtract), .start(pru_start),
        .in_idle(in_idle), .in_load_2(in_load_2),
        .pal_red(pal_red), .pal_green(pal_green), .pal_blue(pal_blue)
    );

    pru_draw_engine #(.fb_width(fb_width), .fb_height(fb_height)) engine0 (
        .clk(clk), .rst_n(rst_n), .start(pru_start),
        .color(color), .row(row), .col(col), .width(width),
        .height_radius(height_radius), .shape_select(shape_select),
        .subtract(subtract), .busy(busy), .done(pru_done),
        .fb_we(fb_we), .fb_waddr(fb_waddr), .fb_wdata(fb_wdata)
    );

    pru_frame_buffer #(.fb_width(fb_width), .fb_height(fb_height)) fbuf0 (
        .clk(clk), .fb_we(fb_we), .fb_waddr(fb_waddr), .fb_wdata(fb_wdata),
        .vga_ctrl_clk(vga_ctrl_clk), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    pru_vga_scan #(.fb_width(fb_width), .fb_height(fb_height)) scan0 (
        .vga_ctrl_clk(vga_ctrl_clk), .rst_n(rst_n), .vga_read(vga_read),
        .rd_data(rd_data),
        .pal_red(pal_red), .pal_green(pal_green), .pal_blue(pal_blue),
        .rd_addr(rd_addr),
        .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue)
    );

endmodule

`default_nettype wire

//--- pru_top_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module pru_top_asserts #(
    parameter bit engine_side = 1'b1
) (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic start,
    input wire logic busy,
    input wire logic done,
    input wire logic fb_we,
    input wire logic bus_ack
);

    int fail_count = 0;

    start_idle: assert property (@(posedge clk) disable iff (!rst_n) $rose(start) |-> !busy)
        else begin
            $error("start rose while busy");
            fail_count++;
        end

    // done only on the edge where busy falls
    done_at_end: assert property (@(posedge clk) disable iff (!rst_n) done |-> $fell(busy))
        else begin
            $error("done without busy falling");
            fail_count++;
        end

    end_gives_done: assert property (@(posedge clk) disable iff (!rst_n)
        engine_side && $fell(busy) |-> done)
        else begin
            $error("busy fell without done");
            fail_count++;
        end

    done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            $error("done longer than one cycle");
            fail_count++;
        end

    we_in_draw: assert property (@(posedge clk) disable iff (!rst_n) fb_we |-> busy)
        else begin
            $error("fb_we outside a draw");
            fail_count++;
        end

    ack_single: assert property (@(posedge clk) disable iff (!rst_n) bus_ack |=> !bus_ack)
        else begin
            $error("bus_ack longer than one cycle");
            fail_count++;
        end

endmodule

bind pru_draw_engine pru_top_asserts #(.engine_side(1'b1)) eng_chk0 (
    .clk(clk), .rst_n(rst_n), .start(start), .busy(busy), .done(done),
    .fb_we(fb_we), .bus_ack(1'b0)
);

bind pru_cmd_regs pru_top_asserts #(.engine_side(1'b0)) regs_chk0 (
    .clk(clk), .rst_n(rst_n), .start(start), .busy(busy), .done(1'b0),
    .fb_we(1'b0), .bus_ack(bus_ack)
);

`default_nettype wire

//--- pru_top_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pru_top_tb
    import pru_pkg::*;
();

    localparam int fb_w   = 64;
    localparam int fb_h   = 48;
    localparam int clk_ns = 20;
    localparam int vga_ns = 40;

    logic        clk;
    logic        rst_n;
    logic        vga_ctrl_clk;
    logic        vga_read;
    logic [31:0] bus_addr;
    logic [31:0] bus_data;
    logic        bus_write;
    logic        bus_ack;
    logic [9:0]  vga_red;
    logic [9:0]  vga_green;
    logic [9:0]  vga_blue;
    logic        pru_start;
    logic        pru_done;
    logic        in_idle;
    logic        in_load_2;

    logic [1:0]  frame_model [fb_h][fb_w];   // expected colour index per pixel
    logic [9:0]  pal_r [4];
    logic [9:0]  pal_g [4];
    logic [9:0]  pal_b [4];

    // stimulus table with one command per row
    pru_shape_e  tbl_shape [$];
    int          tbl_row [$];
    int          tbl_col [$];
    int          tbl_width [$];
    int          tbl_hr [$];
    int          tbl_color [$];
    bit          tbl_sub [$];
    bit          tbl_check [$];   // full readback after this row

    int          value_errors = 0;
    int          proto_errors = 0;
    int          done_count = 0;
    int          start_count = 0;
    int          cmds_sent = 0;
    int          seed;
    bit          table_ready = 1'b0;
    longint      watch_ns;

    pru_top #(.fb_width(fb_w), .fb_height(fb_h)) dut0 (
        .clk(clk), .rst_n(rst_n), .vga_ctrl_clk(vga_ctrl_clk), .vga_read(vga_read),
        .bus_addr(bus_addr), .bus_data(bus_data), .bus_write(bus_write),
        .bus_ack(bus_ack), .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue),
        .pru_start(pru_start), .pru_done(pru_done),
        .in_idle(in_idle), .in_load_2(in_load_2)
    );

    always #(clk_ns / 2) clk = ~clk;
    always #(vga_ns / 2) vga_ctrl_clk = ~vga_ctrl_clk;

    // strobes counted away from the rising edge
    always @(negedge clk) begin
        if (pru_done)
            done_count++;
        if (pru_start)
            start_count++;
    end

    task automatic add_row(input pru_shape_e shape, input int r, input int c, input int w,
                           input int hr, input int color, input bit sub, input bit check);
        tbl_shape.push_back(shape);
        tbl_row.push_back(r);
        tbl_col.push_back(c);
        tbl_width.push_back(w);
        tbl_hr.push_back(hr);
        tbl_color.push_back(color);
        tbl_sub.push_back(sub);
        tbl_check.push_back(check);
    endtask

    task automatic build_table();
        pru_shape_e s;
        add_row(shape_rect, 0, 0, fb_w, fb_h, 0, 0, 1);     // clear the frame
        add_row(shape_rect, 4, 6, 20, 10, 1, 0, 0);
        add_row(shape_rect, 20, 30, 12, 8, 2, 0, 0);
        add_row(shape_rect, 40, 50, 30, 20, 3, 0, 0);       // off right and bottom
        add_row(shape_rect, 10, 60, 9, 3, 2, 0, 0);         // must not wrap into row 11
        add_row(shape_circle, 30, 20, 0, 7, 3, 0, 0);
        add_row(shape_circle, 2, 3, 0, 6, 1, 0, 0);         // top-left corner
        add_row(shape_circle, 45, 62, 0, 5, 2, 0, 0);
        add_row(shape_none, 5, 5, 3, 3, 3, 0, 0);
        for (int k = 0; k < 4; k++) begin
            s = ($unsigned($random(seed)) % 2) ? shape_circle : shape_rect;
            add_row(s, $unsigned($random(seed)) % 56, $unsigned($random(seed)) % 72,
                    1 + $unsigned($random(seed)) % 20,
                    (s == shape_circle) ? $unsigned($random(seed)) % 8
                                        : 1 + $unsigned($random(seed)) % 16,
                    $unsigned($random(seed)) % 4, 0, 0);
        end
        add_row(shape_rect, 22, 25, 10, 6, 1, 1, 0);        // erase part of rect 2
        add_row(shape_circle, 30, 20, 0, 3, 2, 1, 1);
    endtask

    function automatic longint box_cycles(input int i);
        longint n;
        case (tbl_shape[i])
            shape_rect:   n = longint'(tbl_width[i]) * longint'(tbl_hr[i]);
            shape_circle: n = longint'(2 * tbl_hr[i] + 1) * longint'(2 * tbl_hr[i] + 1);
            default:      n = 1;
        endcase
        return (n > 0) ? n : 1;
    endfunction

    task automatic plot(input int y, input int x, input logic [1:0] val);
        if (x >= 0 && x < fb_w && y >= 0 && y < fb_h)
            frame_model[y][x] = val;
    endtask

    task automatic model_shape(input int i);
        logic [1:0] val;
        int         r;
        val = tbl_sub[i] ? 2'd0 : 2'(tbl_color[i]);
        r = tbl_hr[i];
        if (tbl_shape[i] == shape_rect) begin
            for (int y = 0; y < tbl_hr[i]; y++)
                for (int x = 0; x < tbl_width[i]; x++)
                    plot(tbl_row[i] + y, tbl_col[i] + x, val);
        end else if (tbl_shape[i] == shape_circle) begin
            for (int dy = -r; dy <= r; dy++)
                for (int dx = -r; dx <= r; dx++)
                    if (dx * dx + dy * dy <= r * r)
                        plot(tbl_row[i] + dy, tbl_col[i] + dx, val);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    // called and left 2 ns after a clk edge
    task automatic write_bus(input logic [31:0] addr, input logic [31:0] data);
        bus_addr  = addr;
        bus_data  = data;
        bus_write = 1'b1;
        @(posedge clk);
        #2;
        while (!bus_ack) begin
            @(posedge clk);
            #2;
        end
        bus_write = 1'b0;
        @(posedge clk);
        #2;
        assert (!bus_ack) else begin
            $display("bus_ack stayed high for more than one cycle at %h", addr);
            proto_errors++;
        end
    endtask

    task automatic send_cmd(input int i);
        logic [31:0] w0;
        logic [31:0] w1;
        w0 = {8'h00, tbl_sub[i], 2'(tbl_shape[i]), 2'(tbl_color[i]),
              9'(tbl_row[i]), 10'(tbl_col[i])};
        w1 = {13'h0000, 9'(tbl_hr[i]), 10'(tbl_width[i])};
        write_bus(pru_addr_cmd0, w0);
        assert (done_count == cmds_sent) else begin
            $display("cmd0 of row %0d acked before the previous draw finished", i);
            proto_errors++;
        end
        check_value("in_load_2", in_load_2, 1);
        check_value("in_idle", in_idle, 0);
        write_bus(pru_addr_cmd1, w1);
        check_value("in_load_2", in_load_2, 0);
        cmds_sent++;
    endtask

    task automatic wait_draws();
        while (done_count != cmds_sent || !in_idle) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic write_pal(input int n, input logic [9:0] r, input logic [9:0] g,
                             input logic [9:0] b);
        pal_r[n] = r;
        pal_g[n] = g;
        pal_b[n] = b;
        write_bus(pru_addr_pal + n, {2'b00, r, g, b});
    endtask

    // one vga_read pulse per pixel with RGB two vga edges later
    task automatic read_frame();
        logic [1:0] idx;
        @(posedge vga_ctrl_clk);
        #2;
        for (int a = 0; a < fb_w * fb_h; a++) begin
            idx = frame_model[a / fb_w][a % fb_w];
            vga_read = 1'b1;
            @(posedge vga_ctrl_clk);
            #2;
            vga_read = 1'b0;
            repeat (2) @(posedge vga_ctrl_clk);
            #2;
            check_value($sformatf("vga_red[%0d]", a), vga_red, pal_r[idx]);
            check_value($sformatf("vga_green[%0d]", a), vga_green, pal_g[idx]);
            check_value($sformatf("vga_blue[%0d]", a), vga_blue, pal_b[idx]);
        end
        @(posedge clk);
        #2;
    endtask

    initial begin
        wait (table_ready);
        #(watch_ns);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        longint cycles;
        int     sc;
        int     sva_fails;
        clk          = 1'b0;
        vga_ctrl_clk = 1'b0;
        rst_n        = 1'b0;
        vga_read     = 1'b0;
        bus_write    = 1'b0;
        bus_addr     = '0;
        bus_data     = '0;
        seed         = 32'ha61a;
        pal_r = '{10'h000, 10'h3ff, 10'h000, 10'h000};
        pal_g = '{10'h000, 10'h000, 10'h3ff, 10'h000};
        pal_b = '{10'h000, 10'h000, 10'h000, 10'h3ff};
        foreach (frame_model[y, x])
            frame_model[y][x] = 2'd0;
        build_table();
        cycles = 0;
        foreach (tbl_shape[i])
            cycles += box_cycles(i) + 12;   // plus bus writes of the row
        watch_ns = 4 * (cycles * clk_ns + 3 * fb_w * fb_h * 3 * vga_ns);
        table_ready = 1'b1;

        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_value("in_idle", in_idle, 1);
        check_value("in_load_2", in_load_2, 0);
        check_value("bus_ack", bus_ack, 0);
        check_value("pru_start", pru_start, 0);
        check_value("pru_done", pru_done, 0);
        check_value("vga_red", vga_red, 0);
        check_value("vga_green", vga_green, 0);
        check_value("vga_blue", vga_blue, 0);

        for (int i = 0; i < tbl_shape.size(); i++) begin
            send_cmd(i);
            model_shape(i);
            if (tbl_check[i]) begin
                wait_draws();
                read_frame();
            end
        end

        // stray cmd1 in idle is acked and dropped
        wait_draws();
        sc = start_count;
        write_bus(pru_addr_cmd1, 32'h0001_2c10);
        repeat (3) @(posedge clk);
        #2;
        check_value("in_idle", in_idle, 1);
        assert (start_count == sc) else begin
            $display("stray cmd1 in idle started a draw");
            proto_errors++;
        end

        write_pal(0, 10'h021, 10'h102, 10'h084);
        write_pal(1, 10'h155, 10'h0aa, 10'h3c0);
        write_pal(2, 10'h012, 10'h345, 10'h2ff);
        write_pal(3, 10'h3a5, 10'h05a, 10'h1e1);
        write_bus(32'h0000_0120, 32'h3fff_ffff);   // unmapped
        read_frame();

        assert (done_count == cmds_sent && start_count == cmds_sent) else begin
            $display("done count %0d and start count %0d do not match %0d commands",
                     done_count, start_count, cmds_sent);
            proto_errors++;
        end
        sva_fails = dut0.engine0.eng_chk0.fail_count + dut0.cmd_regs0.regs_chk0.fail_count;
        $display("errors: %0d value, %0d protocol, %0d assertion",
                 value_errors, proto_errors, sva_fails);
        if (value_errors + proto_errors + sva_fails == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- pru_top.f
pru_pkg.sv
pru_cmd_regs.sv
pru_draw_engine.sv
pru_frame_buffer.sv
pru_vga_scan.sv
pru_top.sv
pru_top_asserts.sv
pru_top_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = pru_top_tb
FILELIST  = pru_top.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
